// ==== verilog/xfifo_pkg.sv ====
package xfifo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Storage geometry

	// Bits in one FIFO word
	localparam int data_width = 16;

	// Number of entries in the memory
	localparam int fifo_depth = 16;

	// Memory address width
	localparam int addr_bits = 4;

	// Pointer width, with one extra wrap bit so full and empty differ
	localparam int ptr_bits = 5;

	////////////////////////////////////////////////////////////////////////////
	// Pointer crossing

	// Busy cycles without an ack before the request is sent again
	// Recovers a crossing lost to reset skew between the two domains
	localparam int ack_timeout = 31;

	// Pointer pusher states, one pusher per controller
	typedef enum logic {
		// Nothing sent yet since reset
		push_idle,
		// A word is in flight, waiting for its ack
		push_busy
	} push_state_t;

endpackage

// ==== verilog/ptr_sync_if.sv ====
interface ptr_sync_if;

	// One-cycle request in the source domain
	logic update;

	// One-cycle acknowledge back in the source domain
	logic ack;

	// Pointer as offered by its owner
	logic [xfifo_pkg::ptr_bits-1:0] ptr_src;

	// Pointer as seen in the other domain
	logic [xfifo_pkg::ptr_bits-1:0] ptr_dst;

	// Controller that owns the pointer
	modport sender (output update, output ptr_src, input ack);

	// Synchronizer moving the word between clocks
	modport xfer (input update, input ptr_src, output ack, output ptr_dst);

	// Controller in the far domain
	modport receiver (input ptr_dst);

endinterface

// ==== verilog/reg_sync.sv ====
module reg_sync (
	ptr_sync_if.xfer wr_side,
	input  logic clk_src,
	input  logic reset_src,
	input  logic clk_dst,
	input  logic reset_dst
);

	// Incoming toggle, two stages plus the last value taken
	logic [1:0] dst_sync;
	logic dst_seen;

	////////////////////////////////////////////////////////////////////////////
	// Source side

	// Flips once per request
	logic src_toggle;

	// Word held steady while the toggle crosses
	logic [xfifo_pkg::ptr_bits-1:0] src_word;

	// Returned toggle, two stages plus the last value seen
	logic [1:0] ret_sync;
	logic ret_seen;

	always_ff @(posedge clk_src) begin
		if (reset_src) begin
			src_toggle <= 1'b0;
		end else if (wr_side.update) begin
			src_toggle <= ~src_toggle;
		end
	end

	// Capture the offered word on each request
	always_ff @(posedge clk_src) begin
		if (wr_side.update) begin
			src_word <= wr_side.ptr_src;
		end
	end

	always_ff @(posedge clk_src) begin
		if (reset_src) begin
			ret_sync <= 2'b00;
			ret_seen <= 1'b0;
		end else begin
			ret_sync <= {ret_sync[0], dst_seen};
			ret_seen <= ret_sync[1];
		end
	end

	// Edge of the returned toggle gives a one-cycle ack
	assign wr_side.ack = ret_sync[1] ^ ret_seen;

	////////////////////////////////////////////////////////////////////////////
	// Destination side

	always_ff @(posedge clk_dst) begin
		if (reset_dst) begin
			dst_sync <= 2'b00;
			dst_seen <= 1'b0;
			wr_side.ptr_dst <= '0;
		end else begin
			dst_sync <= {dst_sync[0], src_toggle};
			dst_seen <= dst_sync[1];
			// Toggle settled, so src_word is stable here
			if (dst_sync[1] != dst_seen) begin
				wr_side.ptr_dst <= src_word;
			end
		end
	end

endmodule

// ==== verilog/fifo_wr_ctrl.sv ====
module fifo_wr_ctrl (
	input  logic wr_clk,
	input  logic wr_reset,
	input  logic wr_en,
	output logic wr_full,
	output logic [xfifo_pkg::ptr_bits-1:0] wr_size,
	output logic wr_overflow,
	output logic mem_we,
	output logic [xfifo_pkg::addr_bits-1:0] mem_addr,
	ptr_sync_if.sender own_ptr,
	ptr_sync_if.receiver peer_ptr
);

	// Counter just wide enough for the ack timeout
	typedef logic [$clog2(xfifo_pkg::ack_timeout + 1)-1:0] ack_cnt_t;

	logic [xfifo_pkg::ptr_bits-1:0] wr_ptr;
	xfifo_pkg::push_state_t push_state;
	ack_cnt_t ack_count;

	////////////////////////////////////////////////////////////////////////////
	// Flags and memory port

	// Free space against the read pointer as last seen here
	// The seen read pointer lags, so this never overstates room
	assign wr_size = xfifo_pkg::ptr_bits'(xfifo_pkg::fifo_depth)
		+ peer_ptr.ptr_dst - wr_ptr;
	assign wr_full = (wr_size == '0);

	// Only accepted writes reach the memory
	assign mem_we = wr_en && !wr_full;
	assign mem_addr = wr_ptr[xfifo_pkg::addr_bits-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Pointer and overflow strobe

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_ptr <= '0;
			wr_overflow <= 1'b0;
		end else begin
			// Rejected write leaves the pointer alone
			wr_overflow <= wr_en && wr_full;
			if (mem_we) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pusher toward the read domain

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			push_state <= xfifo_pkg::push_idle;
			own_ptr.update <= 1'b0;
			own_ptr.ptr_src <= '0;
			ack_count <= '0;
		end else begin
			own_ptr.update <= 1'b0;
			case (push_state)
				xfifo_pkg::push_idle: begin
					// First send after reset
					own_ptr.update <= 1'b1;
					own_ptr.ptr_src <= wr_ptr;
					ack_count <= '0;
					push_state <= xfifo_pkg::push_busy;
				end
				xfifo_pkg::push_busy: begin
					if (own_ptr.ack) begin
						// Previous word landed, send the current one
						own_ptr.update <= 1'b1;
						own_ptr.ptr_src <= wr_ptr;
						ack_count <= '0;
					end else if (ack_count == ack_cnt_t'(xfifo_pkg::ack_timeout)) begin
						// Ack lost, ask again with the same word
						own_ptr.update <= 1'b1;
						ack_count <= '0;
					end else begin
						ack_count <= ack_count + 1'b1;
					end
				end
				default: push_state <= xfifo_pkg::push_idle;
			endcase
		end
	end

endmodule

// ==== verilog/fifo_rd_ctrl.sv ====
module fifo_rd_ctrl (
	input  logic rd_clk,
	input  logic rd_reset,
	input  logic rd_en,
	output logic rd_empty,
	output logic [xfifo_pkg::ptr_bits-1:0] rd_size,
	output logic rd_underflow,
	output logic mem_re,
	output logic [xfifo_pkg::addr_bits-1:0] mem_addr,
	ptr_sync_if.sender own_ptr,
	ptr_sync_if.receiver peer_ptr
);

	// Counter just wide enough for the ack timeout
	typedef logic [$clog2(xfifo_pkg::ack_timeout + 1)-1:0] ack_cnt_t;

	logic [xfifo_pkg::ptr_bits-1:0] rd_ptr;
	xfifo_pkg::push_state_t push_state;
	ack_cnt_t ack_count;

	////////////////////////////////////////////////////////////////////////////
	// Flags and memory port

	// Words available per the write pointer seen here
	// Seen pointer lags the real one, so reads never run ahead
	assign rd_size = peer_ptr.ptr_dst - rd_ptr;
	assign rd_empty = (peer_ptr.ptr_dst == rd_ptr);

	// Only accepted reads touch the memory output
	assign mem_re = rd_en && !rd_empty;
	assign mem_addr = rd_ptr[xfifo_pkg::addr_bits-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Pointer and underflow strobe

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_ptr <= '0;
			rd_underflow <= 1'b0;
		end else begin
			// Rejected read leaves the pointer alone
			rd_underflow <= rd_en && rd_empty;
			if (mem_re) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pusher toward the write domain

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			push_state <= xfifo_pkg::push_idle;
			own_ptr.update <= 1'b0;
			own_ptr.ptr_src <= '0;
			ack_count <= '0;
		end else begin
			own_ptr.update <= 1'b0;
			case (push_state)
				xfifo_pkg::push_idle: begin
					// Kick off the loop after reset
					own_ptr.update <= 1'b1;
					own_ptr.ptr_src <= rd_ptr;
					ack_count <= '0;
					push_state <= xfifo_pkg::push_busy;
				end
				xfifo_pkg::push_busy: begin
					if (own_ptr.ack) begin
						// Freed space goes out right away
						own_ptr.update <= 1'b1;
						own_ptr.ptr_src <= rd_ptr;
						ack_count <= '0;
					end else if (ack_count == ack_cnt_t'(xfifo_pkg::ack_timeout)) begin
						// Far side probably missed it, pulse again
						own_ptr.update <= 1'b1;
						ack_count <= '0;
					end else begin
						ack_count <= ack_count + 1'b1;
					end
				end
				default: push_state <= xfifo_pkg::push_idle;
			endcase
		end
	end

endmodule

// ==== verilog/fifo_dp_mem.sv ====
module fifo_dp_mem (
	input  logic wr_clk,
	input  logic wr_en,
	input  logic [xfifo_pkg::addr_bits-1:0] wr_addr,
	input  logic [xfifo_pkg::data_width-1:0] wr_data,
	input  logic rd_clk,
	input  logic rd_en,
	input  logic [xfifo_pkg::addr_bits-1:0] rd_addr,
	output logic [xfifo_pkg::data_width-1:0] rd_data
);

	// Storage array, contents undefined until written
	logic [xfifo_pkg::data_width-1:0] mem [xfifo_pkg::fifo_depth];

	////////////////////////////////////////////////////////////////////////////
	// Write port

	always_ff @(posedge wr_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port

	// Output holds its word until the next accepted read
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== verilog/cross_clock_fifo.sv ====
module cross_clock_fifo (
	// Write domain
	input  logic wr_clk,
	input  logic wr_reset,
	input  logic wr_en,
	input  logic [xfifo_pkg::data_width-1:0] wr_data,
	output logic [xfifo_pkg::ptr_bits-1:0] wr_size,
	output logic wr_full,
	output logic wr_overflow,

	// Read domain
	input  logic rd_clk,
	input  logic rd_reset,
	input  logic rd_en,
	output logic [xfifo_pkg::data_width-1:0] rd_data,
	output logic [xfifo_pkg::ptr_bits-1:0] rd_size,
	output logic rd_empty,
	output logic rd_underflow
);

	// Accepted accesses and their addresses
	logic mem_we;
	logic mem_re;
	logic [xfifo_pkg::addr_bits-1:0] mem_wr_addr;
	logic [xfifo_pkg::addr_bits-1:0] mem_rd_addr;

	// Write pointer into the read domain, read pointer back
	ptr_sync_if wr_ptr_x ();
	ptr_sync_if rd_ptr_x ();

	////////////////////////////////////////////////////////////////////////////
	// Controllers, one per domain

	fifo_wr_ctrl u_wr (
		.wr_clk      (wr_clk),
		.wr_reset    (wr_reset),
		.wr_en       (wr_en),
		.wr_full     (wr_full),
		.wr_size     (wr_size),
		.wr_overflow (wr_overflow),
		.mem_we      (mem_we),
		.mem_addr    (mem_wr_addr),
		.own_ptr     (wr_ptr_x.sender),
		.peer_ptr    (rd_ptr_x.receiver)
	);

	fifo_rd_ctrl u_rd (
		.rd_clk       (rd_clk),
		.rd_reset     (rd_reset),
		.rd_en        (rd_en),
		.rd_empty     (rd_empty),
		.rd_size      (rd_size),
		.rd_underflow (rd_underflow),
		.mem_re       (mem_re),
		.mem_addr     (mem_rd_addr),
		.own_ptr      (rd_ptr_x.sender),
		.peer_ptr     (wr_ptr_x.receiver)
	);

	////////////////////////////////////////////////////////////////////////////
	// Pointer crossings

	// wr_clk to rd_clk
	reg_sync u_sync_wr (
		.wr_side   (wr_ptr_x.xfer),
		.clk_src   (wr_clk),
		.reset_src (wr_reset),
		.clk_dst   (rd_clk),
		.reset_dst (rd_reset)
	);

	// rd_clk to wr_clk
	reg_sync u_sync_rd (
		.wr_side   (rd_ptr_x.xfer),
		.clk_src   (rd_clk),
		.reset_src (rd_reset),
		.clk_dst   (wr_clk),
		.reset_dst (wr_reset)
	);

	////////////////////////////////////////////////////////////////////////////
	// Storage

	fifo_dp_mem u_mem (
		.wr_clk  (wr_clk),
		.wr_en   (mem_we),
		.wr_addr (mem_wr_addr),
		.wr_data (wr_data),
		.rd_clk  (rd_clk),
		.rd_en   (mem_re),
		.rd_addr (mem_rd_addr),
		.rd_data (rd_data)
	);

endmodule

// ==== sim/cross_clock_fifo_assert.sv ====
module cross_clock_fifo_assert (
	input logic wr_clk,
	input logic wr_reset,
	input logic wr_en,
	input logic wr_full,
	input logic [xfifo_pkg::ptr_bits-1:0] wr_size,
	input logic wr_overflow,
	input logic rd_clk,
	input logic rd_reset,
	input logic rd_en,
	input logic rd_empty,
	input logic [xfifo_pkg::ptr_bits-1:0] rd_size,
	input logic rd_underflow
);

	// Sizes never run past the depth on either side
	assert property (@(posedge rd_clk) disable iff (rd_reset)
		rd_size <= xfifo_pkg::fifo_depth)
		else $error("rd_size above the FIFO depth");
	assert property (@(posedge wr_clk) disable iff (wr_reset)
		wr_size <= xfifo_pkg::fifo_depth)
		else $error("wr_size above the FIFO depth");

	// Strobes follow a rejected access one cycle earlier
	assert property (@(posedge wr_clk) disable iff (wr_reset)
		$rose(wr_overflow) |-> $past(wr_en && wr_full))
		else $error("wr_overflow rose without a write into a full FIFO");
	assert property (@(posedge rd_clk) disable iff (rd_reset)
		$rose(rd_underflow) |-> $past(rd_en && rd_empty))
		else $error("rd_underflow rose without a read from an empty FIFO");

endmodule

bind cross_clock_fifo cross_clock_fifo_assert u_assert (.*);

// ==== sim/cross_clock_fifo_tb.sv ====
module cross_clock_fifo_tb;

	// Run limit in rd_clk cycles, about three times the summed test length
	localparam int max_cycles = 6000;
	// Bounded wait for a crossing to settle
	localparam int settle_limit = 200;
	localparam int stream_words = 200;

	logic wr_clk;
	logic wr_reset;
	logic wr_en;
	logic [xfifo_pkg::data_width-1:0] wr_data;
	logic [xfifo_pkg::ptr_bits-1:0] wr_size;
	logic wr_full;
	logic wr_overflow;
	logic rd_clk;
	logic rd_reset;
	logic rd_en;
	logic [xfifo_pkg::data_width-1:0] rd_data;
	logic [xfifo_pkg::ptr_bits-1:0] rd_size;
	logic rd_empty;
	logic rd_underflow;

	// Expected words in write order
	logic [xfifo_pkg::data_width-1:0] scoreboard [$];
	// Word most recently taken off the scoreboard
	logic [xfifo_pkg::data_width-1:0] last_word;
	logic [31:0] rng_state;
	int error_count;
	int cycle_count;

	cross_clock_fifo u_cross_clock_fifo (
		.wr_clk       (wr_clk),
		.wr_reset     (wr_reset),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.wr_size      (wr_size),
		.wr_full      (wr_full),
		.wr_overflow  (wr_overflow),
		.rd_clk       (rd_clk),
		.rd_reset     (rd_reset),
		.rd_en        (rd_en),
		.rd_data      (rd_data),
		.rd_size      (rd_size),
		.rd_empty     (rd_empty),
		.rd_underflow (rd_underflow)
	);

	////////////////////////////////////////////////////////////////////////////
	// Clocks and run limit

	// Periods 20 and 26, so the edges drift against each other
	always #10 rd_clk = ~rd_clk;
	always #13 wr_clk = ~wr_clk;

	always @(posedge rd_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Run stopped: no finish within %0d rd_clk cycles", max_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			error_count++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string text);
		error_count++;
		$display("%s", text);
	endtask

	// Called at a wr_clk falling edge, where wr_full is stable
	task automatic write_word(input logic [xfifo_pkg::data_width-1:0] data, output bit accepted);
		accepted = !wr_full;
		if (accepted) begin
			scoreboard.push_back(data);
		end
		wr_en = 1'b1;
		wr_data = data;
		@(negedge wr_clk);
		wr_en = 1'b0;
	endtask

	// Called at a rd_clk falling edge, word shows one cycle later
	task automatic read_word(input string name, output bit accepted);
		logic [xfifo_pkg::data_width-1:0] expected;
		accepted = !rd_empty;
		rd_en = 1'b1;
		@(negedge rd_clk);
		rd_en = 1'b0;
		if (accepted && scoreboard.size() == 0) begin
			report_failure({name, ": a word was read while none was expected"});
		end else if (accepted) begin
			expected = scoreboard.pop_front();
			last_word = expected;
			check_value(name, expected, rd_data);
		end
	endtask

	task automatic wait_rd_size(input string name, input int target);
		int cycles;
		cycles = 0;
		while (rd_size != target && cycles < settle_limit) begin
			@(negedge rd_clk);
			cycles++;
		end
		if (rd_size != target) begin
			report_failure($sformatf("%s: rd_size never reached %0d", name, target));
		end
	endtask

	task automatic wait_wr_size(input string name, input int target);
		int cycles;
		cycles = 0;
		while (wr_size != target && cycles < settle_limit) begin
			@(negedge wr_clk);
			cycles++;
		end
		if (wr_size != target) begin
			report_failure($sformatf("%s: wr_size never reached %0d", name, target));
		end
	endtask

	task automatic fill_words(input string name, input int count);
		logic [31:0] word;
		bit accepted;
		for (int i = 0; i < count; i++) begin
			@(negedge wr_clk);
			word = next_random();
			write_word(word[xfifo_pkg::data_width-1:0], accepted);
			check_value(name, 1, accepted);
		end
	endtask

	task automatic drain_words(input string name, input int count);
		bit accepted;
		for (int i = 0; i < count; i++) begin
			@(negedge rd_clk);
			read_word(name, accepted);
			check_value(name, 1, accepted);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_state();
		@(negedge wr_clk);
		check_value("reset_state", xfifo_pkg::fifo_depth, wr_size);
		check_value("reset_state", 0, wr_full);
		check_value("reset_state", 0, wr_overflow);
		@(negedge rd_clk);
		check_value("reset_state", 0, rd_size);
		check_value("reset_state", 1, rd_empty);
		check_value("reset_state", 0, rd_underflow);
	endtask

	task automatic test_fill_drain();
		fill_words("fill_drain", xfifo_pkg::fifo_depth);
		wait_rd_size("fill_drain", xfifo_pkg::fifo_depth);
		drain_words("fill_drain", xfifo_pkg::fifo_depth);
	endtask

	task automatic test_overflow();
		bit accepted;
		// Wait for the freed space to come back to the writer
		wait_wr_size("overflow", xfifo_pkg::fifo_depth);
		fill_words("overflow", xfifo_pkg::fifo_depth);
		check_value("overflow", 1, wr_full);
		write_word(16'hdead, accepted);
		check_value("overflow", 0, accepted);
		check_value("overflow", 1, wr_overflow);
		@(negedge wr_clk);
		check_value("overflow", 0, wr_overflow);
		// Extra word must be absent from the drained data
		wait_rd_size("overflow", xfifo_pkg::fifo_depth);
		drain_words("overflow", xfifo_pkg::fifo_depth);
	endtask

	task automatic test_underflow();
		@(negedge rd_clk);
		check_value("underflow", 1, rd_empty);
		rd_en = 1'b1;
		@(negedge rd_clk);
		rd_en = 1'b0;
		check_value("underflow", 1, rd_underflow);
		check_value("underflow", 0, rd_size);
		// Output keeps the last word drained
		check_value("underflow", last_word, rd_data);
		@(negedge rd_clk);
		check_value("underflow", 0, rd_underflow);
		// Traffic after the rejected read
		fill_words("underflow", 1);
		wait_rd_size("underflow", 1);
		drain_words("underflow", 1);
	endtask

	task automatic test_size_agreement();
		int count;
		logic [31:0] pick;
		pick = next_random();
		count = (pick % 15) + 1;
		wait_wr_size("size_agreement", xfifo_pkg::fifo_depth);
		fill_words("size_agreement", count);
		wait_rd_size("size_agreement", count);
		check_value("size_agreement", count, rd_size);
		@(negedge wr_clk);
		check_value("size_agreement", xfifo_pkg::fifo_depth - count, wr_size);
		drain_words("size_agreement", count);
	endtask

	task automatic test_streaming();
		int sent;
		int received;
		bit wr_ok;
		bit rd_ok;
		logic [31:0] wr_pick;
		logic [31:0] rd_pick;
		sent = 0;
		received = 0;
		fork
			while (sent < stream_words) begin
				@(negedge wr_clk);
				wr_pick = next_random();
				// About one slot in four stays idle
				if (!wr_full && wr_pick[17:16] != 2'b00) begin
					write_word(wr_pick[xfifo_pkg::data_width-1:0], wr_ok);
					sent++;
				end
			end
			while (received < stream_words) begin
				@(negedge rd_clk);
				rd_pick = next_random();
				if (!rd_empty && rd_pick[17:16] != 2'b00) begin
					read_word("streaming", rd_ok);
					received++;
				end
			end
		join
		@(negedge rd_clk);
		check_value("streaming", 1, rd_empty);
		check_value("streaming", 0, rd_size);
		check_value("streaming", 0, scoreboard.size());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		wr_clk = 1'b0;
		rd_clk = 1'b0;
		wr_reset = 1'b1;
		rd_reset = 1'b1;
		wr_en = 1'b0;
		rd_en = 1'b0;
		wr_data = '0;
		rng_state = 32'd68;
		error_count = 0;
		cycle_count = 0;
		// Both resets held for 16 rd_clk cycles
		repeat (16) @(posedge rd_clk);
		@(negedge rd_clk);
		rd_reset = 1'b0;
		@(negedge wr_clk);
		wr_reset = 1'b0;
		test_reset_state();
		test_fill_drain();
		test_overflow();
		test_underflow();
		test_size_agreement();
		test_streaming();
		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
verilog/xfifo_pkg.sv
verilog/ptr_sync_if.sv
verilog/reg_sync.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/fifo_dp_mem.sv
verilog/cross_clock_fifo.sv
sim/cross_clock_fifo_assert.sv
sim/cross_clock_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: cross_clock_fifo

sources:
  - files:
      - verilog/xfifo_pkg.sv
      - verilog/ptr_sync_if.sv
      - verilog/reg_sync.sv
      - verilog/fifo_wr_ctrl.sv
      - verilog/fifo_rd_ctrl.sv
      - verilog/fifo_dp_mem.sv
      - verilog/cross_clock_fifo.sv
  - target: simulation
    files:
      - sim/cross_clock_fifo_assert.sv
      - sim/cross_clock_fifo_tb.sv
